// File: eth_loop.f
hw/eth_loop_pkg.sv
hw/xgmii_rx_decode.sv
hw/frame_monitor.sv
hw/xgmii_tx_encode.sv
hw/activity_led.sv
hw/eth_loop_core.sv
verif/tb_eth_loop_core.sv

// File: run_sim.sh
#!/bin/sh
# Build the eth_loop testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=sim_eth_loop

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_eth_loop_core \
        -f eth_loop.f \
        --Mdir "$OBJ" -o "$BIN"; then
    echo "Verilator build failed"
    exit 1
fi

if ! "./$OBJ/$BIN" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error status"
    exit 1
fi

cat "$LOG"

if grep -q "^TESTS PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: verif/tb_eth_loop_core.sv
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// eth_loop core testbench
// Directed XGMII frames through the loopback, output stream
// checked against an expected queue, counters and LEDs checked
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_eth_loop_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int min_len    = 64;
    localparam int max_len    = 128;
    localparam int act_cycles = 8;
    localparam int num_random = 20;

    // Frame slots of at most 40 cycles each, plus margin
    localparam int frame_slots    = num_random + 5;
    localparam int timeout_cycles = frame_slots * 40 + 1000;

    localparam logic [63:0] idle_word = {8{eth_loop_pkg::char_idle}};
    localparam logic [63:0] err_word  = {8{eth_loop_pkg::char_error}};
    localparam logic [63:0] preamble  = {8'hD5, {6{8'h55}}, eth_loop_pkg::char_start};

    typedef struct packed {
        logic [eth_loop_pkg::xgmii_data_w-1:0] d;
        logic [eth_loop_pkg::xgmii_ctrl_w-1:0] c;
    } xgmii_word_t;

    logic                                  clk;
    logic                                  arst_n;
    logic [eth_loop_pkg::xgmii_data_w-1:0] rxd;
    logic [eth_loop_pkg::xgmii_ctrl_w-1:0] rxc;
    logic [eth_loop_pkg::xgmii_data_w-1:0] txd;
    logic [eth_loop_pkg::xgmii_ctrl_w-1:0] txc;
    logic [eth_loop_pkg::count_w-1:0]      good_frames;
    logic [eth_loop_pkg::count_w-1:0]      bad_frames;
    logic                                  act_led;
    logic                                  err_led;

    xgmii_word_t                      exp_q[$];
    xgmii_word_t                      out_exp;
    logic [31:0]                      rng_state;
    logic [eth_loop_pkg::count_w-1:0] exp_good;
    logic [eth_loop_pkg::count_w-1:0] exp_bad;

    eth_loop_core #(
        .MIN_LEN    (min_len),
        .MAX_LEN    (max_len),
        .ACT_CYCLES (act_cycles)
    ) i_eth_loop_core (
        .clk         (clk),
        .arst_n      (arst_n),
        .rxd         (rxd),
        .rxc         (rxc),
        .txd         (txd),
        .txc         (txc),
        .good_frames (good_frames),
        .bad_frames  (bad_frames),
        .act_led     (act_led),
        .err_led     (err_led)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_value(input string what, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    // One word per clock, expected output queued alongside
    task automatic drive_word(input logic [63:0] d, input logic [7:0] c,
                              input logic [63:0] exp_d, input logic [7:0] exp_c);
        @(posedge clk);
        rxd <= d;
        rxc <= c;
        exp_q.push_back(xgmii_word_t'{d: exp_d, c: exp_c});
    endtask

    task automatic drive_idle(input int n);
        repeat (n) drive_word(idle_word, 8'hFF, idle_word, 8'hFF);
    endtask

    // Start, data words, terminate padded with idle
    // err_after >= 0 puts an error word before that data word
    task automatic send_frame(input int len, input int err_after);
        int          n_data;
        int          lane;
        logic        bad;
        logic [63:0] word;
        logic [63:0] exp_word;
        logic [7:0]  ctrl;
        n_data = len / 8;
        lane   = len % 8;
        bad    = err_after >= 0 || len < min_len || len > max_len;
        drive_word(preamble, 8'h01, preamble, 8'h01);
        for (int i = 0; i < n_data; i++) begin
            if (i == err_after) begin
                word = {next_rand(), next_rand()};
                word[31:24] = eth_loop_pkg::char_error;
                // Control lane 3 with error comes out as an all-error word
                drive_word(word, 8'h08, err_word, 8'hFF);
            end
            word = {next_rand(), next_rand()};
            drive_word(word, 8'h00, word, 8'h00);
        end
        word = {next_rand(), next_rand()};
        for (int b = 0; b < 8; b++) begin
            if (b > lane) begin
                word[8*b +: 8] = eth_loop_pkg::char_idle;
            end
        end
        word[8*lane +: 8] = eth_loop_pkg::char_term;
        ctrl = 8'hFF << lane;
        exp_word = word;
        if (bad) begin
            exp_word[8*lane +: 8] = eth_loop_pkg::char_error;
        end
        drive_word(word, ctrl, exp_word, ctrl);
        if (bad) begin
            exp_bad = exp_bad + 1'b1;
        end else begin
            exp_good = exp_good + 1'b1;
        end
    endtask

    // Gap long enough for the verdict to reach the counters
    task automatic settle_and_check_counts();
        drive_idle(4);
        @(negedge clk);
        check_value("good_frames", 64'(good_frames), 64'(exp_good));
        check_value("bad_frames", 64'(bad_frames), 64'(exp_bad));
    endtask

    task automatic test_reset_idle();
        @(negedge clk);
        check_value("txd after reset", txd, idle_word);
        check_value("txc after reset", 64'(txc), 64'(8'hFF));
        check_value("good_frames after reset", 64'(good_frames), 64'd0);
        check_value("bad_frames after reset", 64'(bad_frames), 64'd0);
        check_value("act_led after reset", 64'(act_led), 64'd0);
        check_value("err_led after reset", 64'(err_led), 64'd0);
        drive_idle(8);
    endtask

    task automatic test_good_frame();
        send_frame(80, -1);
        settle_and_check_counts();
        check_value("act_led after good frame", 64'(act_led), 64'd1);
    endtask

    task automatic test_bad_lengths();
        send_frame(40, -1);
        settle_and_check_counts();
        check_value("err_led after short frame", 64'(err_led), 64'd1);
        send_frame(200, -1);
        settle_and_check_counts();
        check_value("err_led after long frame", 64'(err_led), 64'd1);
    endtask

    task automatic test_injected_error();
        send_frame(96, 5);
        settle_and_check_counts();
        check_value("err_led after damaged frame", 64'(err_led), 64'd1);
    endtask

    // Lane cycles with the index so every term_lane appears
    task automatic test_random_frames();
        int len;
        for (int i = 0; i < num_random; i++) begin
            len = min_len + 8 * int'(next_rand() % 32'd8) + i % 8;
            send_frame(len, -1);
            if (i < num_random - 1) begin
                settle_and_check_counts();
            end
        end
    endtask

    // Pulse lands 2 edges after the terminate drive, LED reload one later
    task automatic test_led_release();
        for (int k = 1; k <= 3 + act_cycles; k++) begin
            drive_idle(1);
            @(negedge clk);
            if (k == 2 + act_cycles) begin
                check_value("act_led last held cycle", 64'(act_led), 64'd1);
            end else if (k == 3 + act_cycles) begin
                check_value("act_led after hold time", 64'(act_led), 64'd0);
            end
        end
        check_value("final good_frames", 64'(good_frames), 64'(exp_good));
        check_value("final bad_frames", 64'(bad_frames), 64'(exp_bad));
    endtask

    // Output stream against the queue, three drives behind
    always @(negedge clk) begin
        if (exp_q.size() >= 4) begin
            out_exp = exp_q.pop_front();
            check_value("txd", txd, out_exp.d);
            check_value("txc", 64'(txc), 64'(out_exp.c));
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: run did not finish within %0d clock cycles", timeout_cycles);
        $display("TESTS FAILED");
        $fatal(1);
    end

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        rxd       = idle_word;
        rxc       = 8'hFF;
        rng_state = 32'd35904;
        exp_good  = '0;
        exp_bad   = '0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        test_reset_idle();
        test_good_frame();
        test_bad_lengths();
        test_injected_error();
        test_random_frames();
        test_led_release();

        // Flush the last words through the compare
        drive_idle(4);
        @(negedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/eth_loop_core.sv
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// eth_loop core
// XGMII loopback through decode, frame monitor and encode,
// with activity and error LEDs stretched from frame verdicts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module eth_loop_core #(
    parameter int MIN_LEN    = 64,
    parameter int MAX_LEN    = 1518,
    parameter int ACT_CYCLES = 16384
) (
    input  wire                                  clk,
    input  wire                                  arst_n,
    input  wire [eth_loop_pkg::xgmii_data_w-1:0] rxd,
    input  wire [eth_loop_pkg::xgmii_ctrl_w-1:0] rxc,
    output wire [eth_loop_pkg::xgmii_data_w-1:0] txd,
    output wire [eth_loop_pkg::xgmii_ctrl_w-1:0] txc,
    output wire [eth_loop_pkg::count_w-1:0]      good_frames,
    output wire [eth_loop_pkg::count_w-1:0]      bad_frames,
    output wire                                  act_led,
    output wire                                  err_led
);

    eth_loop_pkg::xgmii_beat_t dec_beat;
    eth_loop_pkg::xgmii_beat_t mon_beat;
    wire                       frame_good;
    wire                       frame_bad;

    // Stage 1
    xgmii_rx_decode i_xgmii_rx_decode (
        .clk    (clk),
        .arst_n (arst_n),
        .rxd    (rxd),
        .rxc    (rxc),
        .beat   (dec_beat)
    );

    // Stage 2
    frame_monitor #(
        .MIN_LEN (MIN_LEN),
        .MAX_LEN (MAX_LEN)
    ) i_frame_monitor (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_beat     (dec_beat),
        .out_beat    (mon_beat),
        .frame_good  (frame_good),
        .frame_bad   (frame_bad),
        .good_frames (good_frames),
        .bad_frames  (bad_frames)
    );

    // Stage 3
    xgmii_tx_encode i_xgmii_tx_encode (
        .clk    (clk),
        .arst_n (arst_n),
        .beat   (mon_beat),
        .txd    (txd),
        .txc    (txc)
    );

    activity_led #(
        .HOLD_CYCLES (ACT_CYCLES)
    ) i_act_led (
        .clk         (clk),
        .arst_n      (arst_n),
        .event_pulse (frame_good),
        .led         (act_led)
    );

    activity_led #(
        .HOLD_CYCLES (ACT_CYCLES)
    ) i_err_led (
        .clk         (clk),
        .arst_n      (arst_n),
        .event_pulse (frame_bad),
        .led         (err_led)
    );

endmodule

`default_nettype wire

// File: hw/activity_led.sv
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LED pulse stretcher
// Holds the LED on for HOLD_CYCLES cycles after the most
// recent event pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module activity_led #(
    parameter int HOLD_CYCLES = 16384
) (
    input  wire  clk,
    input  wire  arst_n,
    input  wire  event_pulse,
    output logic led
);

    localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

    logic [CNT_W-1:0] count_q;

    // Every event restarts the hold time
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count_q <= '0;
        end else if (event_pulse) begin
            count_q <= CNT_W'(HOLD_CYCLES);
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    assign led = count_q != '0;

endmodule

`default_nettype wire

// File: hw/xgmii_tx_encode.sv
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XGMII transmit encoder
// Rebuilds data and control lanes from each beat, putting an
// error character in place of terminate on bad frames
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module xgmii_tx_encode (
    input  wire                                    clk,
    input  wire                                    arst_n,
    input  wire eth_loop_pkg::xgmii_beat_t         beat,
    output logic [eth_loop_pkg::xgmii_data_w-1:0]  txd,
    output logic [eth_loop_pkg::xgmii_ctrl_w-1:0]  txc
);

    logic [eth_loop_pkg::xgmii_data_w-1:0] txd_d;
    logic [eth_loop_pkg::xgmii_ctrl_w-1:0] txc_d;
    logic [7:0]                            end_char;

    // Failed frames end in error so the fault reaches the far side
    assign end_char = beat.bad ? eth_loop_pkg::char_error : eth_loop_pkg::char_term;

    always_comb begin
        txd_d = {8{eth_loop_pkg::char_idle}};
        txc_d = '1;
        case (beat.kind)
            eth_loop_pkg::kind_start: begin
                txd_d = {beat.data[63:8], eth_loop_pkg::char_start};
                txc_d = 8'h01;
            end
            eth_loop_pkg::kind_data: begin
                txd_d = beat.data;
                txc_d = '0;
            end
            eth_loop_pkg::kind_term: begin
                for (int i = 0; i < eth_loop_pkg::xgmii_ctrl_w; i++) begin
                    if (i < beat.term_lane) begin
                        txd_d[8*i +: 8] = beat.data[8*i +: 8];
                        txc_d[i]        = 1'b0;
                    end else if (i == beat.term_lane) begin
                        txd_d[8*i +: 8] = end_char;
                    end
                    // Lanes above the terminate keep idle
                end
            end
            eth_loop_pkg::kind_error: begin
                txd_d = {8{eth_loop_pkg::char_error}};
            end
            default: ;
        endcase
    end

    // Output comes up idle out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            txd <= {8{eth_loop_pkg::char_idle}};
            txc <= '1;
        end else begin
            txd <= txd_d;
            txc <= txc_d;
        end
    end

    // Start beat leaves as a start control character in lane 0
    a_start_ctrl: assert property (@(posedge clk) disable iff (!arst_n)
        $past(beat.kind) == eth_loop_pkg::kind_start
        |-> txc[0] && txd[7:0] == eth_loop_pkg::char_start)
        else $error("start sent without lane 0 control bit");

endmodule

`default_nettype wire

// File: hw/frame_monitor.sv
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame monitor
// Tracks frames between start and terminate, checks length,
// marks failed terminates and counts good and bad frames
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module frame_monitor #(
    parameter int MIN_LEN = 64,
    parameter int MAX_LEN = 1518
) (
    input  wire                                clk,
    input  wire                                arst_n,
    input  wire eth_loop_pkg::xgmii_beat_t     in_beat,
    output eth_loop_pkg::xgmii_beat_t          out_beat,
    output logic                               frame_good,
    output logic                               frame_bad,
    output logic [eth_loop_pkg::count_w-1:0]   good_frames,
    output logic [eth_loop_pkg::count_w-1:0]   bad_frames
);

    // Room for MAX_LEN plus one data beat and a terminate lane
    localparam int LEN_W = $clog2(MAX_LEN + 16);

    eth_loop_pkg::mon_state_e               state_q;
    eth_loop_pkg::mon_state_e               state_d;
    logic [LEN_W-1:0]                       len_q;
    logic [LEN_W-1:0]                       len_d;
    logic [LEN_W-1:0]                       frame_len;
    logic                                   len_ok;
    logic                                   damaged_q;
    logic                                   damaged_d;
    logic                                   good_d;
    logic                                   bad_d;
    eth_loop_pkg::word_kind_e               kind_q;
    logic [2:0]                             lane_q;
    logic                                   mark_q;
    logic [eth_loop_pkg::xgmii_data_w-1:0]  data_q;

    assign frame_len = len_q + LEN_W'(in_beat.term_lane);
    assign len_ok    = frame_len >= LEN_W'(MIN_LEN) && frame_len <= LEN_W'(MAX_LEN);

    always_comb begin
        state_d   = state_q;
        len_d     = len_q;
        damaged_d = damaged_q;
        good_d    = 1'b0;
        bad_d     = 1'b0;
        case (state_q)
            eth_loop_pkg::mon_idle: begin
                // Stray data, terminate and error pass uncounted
                if (in_beat.kind == eth_loop_pkg::kind_start) begin
                    state_d   = eth_loop_pkg::mon_frame;
                    len_d     = '0;
                    damaged_d = 1'b0;
                end
            end
            eth_loop_pkg::mon_frame: begin
                case (in_beat.kind)
                    eth_loop_pkg::kind_data: begin
                        // Stop growing once past MAX_LEN
                        if (len_q <= LEN_W'(MAX_LEN)) begin
                            len_d = len_q + LEN_W'(8);
                        end
                    end
                    eth_loop_pkg::kind_error: damaged_d = 1'b1;
                    eth_loop_pkg::kind_term: begin
                        state_d = eth_loop_pkg::mon_idle;
                        good_d  = !damaged_q && len_ok;
                        bad_d   = !(!damaged_q && len_ok);
                    end
                    eth_loop_pkg::kind_start: begin
                        // Open frame dropped, new one begins
                        bad_d     = 1'b1;
                        len_d     = '0;
                        damaged_d = 1'b0;
                    end
                    default: begin
                        // Idle inside a frame
                        bad_d   = 1'b1;
                        state_d = eth_loop_pkg::mon_idle;
                    end
                endcase
            end
            default: state_d = eth_loop_pkg::mon_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= eth_loop_pkg::mon_idle;
            len_q       <= '0;
            damaged_q   <= 1'b0;
            frame_good  <= 1'b0;
            frame_bad   <= 1'b0;
            good_frames <= '0;
            bad_frames  <= '0;
            kind_q      <= eth_loop_pkg::kind_idle;
            lane_q      <= 3'd0;
            mark_q      <= 1'b0;
        end else begin
            state_q    <= state_d;
            len_q      <= len_d;
            damaged_q  <= damaged_d;
            frame_good <= good_d;
            frame_bad  <= bad_d;
            if (good_d) begin
                good_frames <= good_frames + 1'b1;
            end
            if (bad_d) begin
                bad_frames <= bad_frames + 1'b1;
            end
            kind_q <= in_beat.kind;
            lane_q <= in_beat.term_lane;
            mark_q <= bad_d && in_beat.kind == eth_loop_pkg::kind_term;
        end
    end

    always_ff @(posedge clk) begin
        data_q <= in_beat.data;
    end

    assign out_beat = '{kind: kind_q, data: data_q, term_lane: lane_q, bad: mark_q};

    a_one_verdict: assert property (@(posedge clk) disable iff (!arst_n)
        !(frame_good && frame_bad))
        else $error("frame judged good and bad at once");

    a_bad_on_term: assert property (@(posedge clk) disable iff (!arst_n)
        out_beat.bad |-> out_beat.kind == eth_loop_pkg::kind_term)
        else $error("bad flag on a beat that is not a terminate");

endmodule

`default_nettype wire

// File: hw/xgmii_rx_decode.sv
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XGMII receive decoder
// Classifies each received word as idle, start, data,
// terminate or error and registers it as a beat
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module xgmii_rx_decode (
    input  wire                                    clk,
    input  wire                                    arst_n,
    input  wire [eth_loop_pkg::xgmii_data_w-1:0]   rxd,
    input  wire [eth_loop_pkg::xgmii_ctrl_w-1:0]   rxc,
    output eth_loop_pkg::xgmii_beat_t              beat
);

    // Byte carried on one lane
    function automatic logic [7:0] lane_char(
        input logic [eth_loop_pkg::xgmii_data_w-1:0] word,
        input logic [2:0]                            lane
    );
        return word[8*lane +: 8];
    endfunction

    // Lowest lane with its control bit set
    function automatic logic [2:0] lowest_lane(
        input logic [eth_loop_pkg::xgmii_ctrl_w-1:0] ctrl
    );
        logic [2:0] lane;
        lane = 3'd0;
        for (int i = eth_loop_pkg::xgmii_ctrl_w - 1; i >= 0; i--) begin
            if (ctrl[i]) begin
                lane = 3'(i);
            end
        end
        return lane;
    endfunction

    eth_loop_pkg::word_kind_e               kind_d;
    eth_loop_pkg::word_kind_e               kind_q;
    logic [2:0]                             ctrl_lane;
    logic [2:0]                             lane_q;
    logic [eth_loop_pkg::xgmii_data_w-1:0]  data_q;

    assign ctrl_lane = lowest_lane(rxc);

    always_comb begin
        if (rxc == '0) begin
            kind_d = eth_loop_pkg::kind_data;
        end else if (rxc == '1 && rxd == {8{eth_loop_pkg::char_idle}}) begin
            kind_d = eth_loop_pkg::kind_idle;
        end else if (rxc == 8'h01 && rxd[7:0] == eth_loop_pkg::char_start) begin
            kind_d = eth_loop_pkg::kind_start;
        end else if (lane_char(rxd, ctrl_lane) == eth_loop_pkg::char_term) begin
            // Lanes below are data by construction, lanes above are ignored
            kind_d = eth_loop_pkg::kind_term;
        end else begin
            kind_d = eth_loop_pkg::kind_error;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            kind_q <= eth_loop_pkg::kind_idle;
            lane_q <= 3'd0;
        end else begin
            kind_q <= kind_d;
            lane_q <= ctrl_lane;
        end
    end

    always_ff @(posedge clk) begin
        data_q <= rxd;
    end

    // Monitor fills in bad later
    assign beat = '{kind: kind_q, data: data_q, term_lane: lane_q, bad: 1'b0};

    // Terminate lane points at the terminate character one cycle back
    a_term_lane: assert property (@(posedge clk) disable iff (!arst_n)
        beat.kind == eth_loop_pkg::kind_term
        |-> lane_char($past(rxd), beat.term_lane) == eth_loop_pkg::char_term)
        else $error("term_lane does not match received terminate");

endmodule

`default_nettype wire

// File: hw/eth_loop_pkg.sv
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// eth_loop shared definitions
// XGMII widths, control character codes, the word-kind and
// monitor-state enums, and the beat carried between stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package eth_loop_pkg;

    // XGMII word geometry
    parameter int xgmii_data_w = 64;
    parameter int xgmii_ctrl_w = 8;

    // Control characters as seen on a control lane
    parameter logic [7:0] char_idle  = 8'h07;
    parameter logic [7:0] char_start = 8'hFB;
    parameter logic [7:0] char_term  = 8'hFD;
    parameter logic [7:0] char_error = 8'hFE;

    // Frame counter width
    parameter int count_w = 16;

    // Class of one received XGMII word
    typedef enum logic [2:0] {
        kind_idle,
        kind_start,
        kind_data,
        kind_term,
        kind_error
    } word_kind_e;

    // Frame monitor state
    typedef enum logic {
        mon_idle,
        mon_frame
    } mon_state_e;

    // One pipeline beat
    // term_lane only means something for kind_term
    // bad is set by the monitor on the terminate of a failed frame
    typedef struct packed {
        word_kind_e              kind;
        logic [xgmii_data_w-1:0] data;
        logic [2:0]              term_lane;
        logic                    bad;
    } xgmii_beat_t;

endpackage

`default_nettype wire
